// File: bench/aluStim.txt
# C addr data : configuration write, values hex
# O op a b result carry zero : op 0 add 1 sub 2 and 3 or 4 xor 5 shift, values hex
O 0 00000005 00000003 00000008 0 0
O 0 FFFFFFFF 00000001 00000000 1 1
O 1 00000009 00000004 00000005 1 0
O 1 00000004 00000009 FFFFFFFB 0 0
O 1 12345678 12345678 00000000 1 1
O 2 F0F0F0F0 FF00FF00 F000F000 0 0
O 3 F0F0F0F0 0F0F0F00 FFFFFFF0 0 0
O 4 AAAAAAAA 55555555 FFFFFFFF 0 0
O 4 DEADBEEF DEADBEEF 00000000 0 1
C 0 00000000
O 5 80000001 00000000 80000001 0 0
O 5 80000001 00000001 00000003 0 0
O 5 80000001 0000001F C0000000 0 0
C 0 00000001
O 5 80000001 00000000 80000001 0 0
O 5 80000001 FFFFFFE1 00000002 0 0
O 5 80000001 0000001F 80000000 0 0
O 0 7FFFFFFF 00000001 80000000 0 0
C 0 00000002
O 5 80000001 00000000 80000001 0 0
O 5 80000001 00000001 C0000000 0 0
O 5 80000001 0000001F 00000003 0 0
C 0 00000003
O 5 80000001 00000000 80000001 0 0
O 5 80000001 00000001 40000000 0 0
O 5 80000001 0000001F 00000001 0 0
O 5 00000001 00000001 00000000 0 1
O 2 0F0F0F0F F0F0F0F0 00000000 0 1

// File: flist.f
hw/aluPkg.sv
hw/shiftPkg.sv
hw/shiftStage.sv
hw/barrelShifter.sv
hw/aluCore.sv
hw/ctrlRegs.sv
hw/aluTop.sv
bench/aluTopTb.sv

// File: Bender.yml
package:
  name: aluExec

sources:
  - hw/aluPkg.sv
  - hw/shiftPkg.sv
  - hw/shiftStage.sv
  - hw/barrelShifter.sv
  - hw/aluCore.sv
  - hw/ctrlRegs.sv
  - hw/aluTop.sv
  - target: test
    files:
      - bench/aluTopTb.sv

// File: bench/aluTopTb.sv
// ALU execution unit testbench
`timescale 1ns/10ps

module aluTopTb;
  import aluPkg::*;
  import shiftPkg::*;

  logic                    clk;
  logic                    rst;
  logic                    inValid;
  AluOp                    inOp;
  logic [DataWidth-1:0]    inA, inB, outResult, cfgWdata, cfgRdata;
  logic                    outValid, outCarry, outZero, cfgWe;
  logic [CfgAddrWidth-1:0] cfgAddr;

  // Expected {zero, carry, result}, test name and sampling cycle per operation
  logic [DataWidth+1:0] expQ[$];
  string                nameQ[$];
  int                   issueQ[$];

  int cycle = 0;
  int passCount = 0;
  int failCount = 0;
  int resultCount = 0;
  int seed = 34;

  aluTop #(.Width(DataWidth)) UUT (
    .clk(clk), .rst(rst), .inValid(inValid), .inOp(inOp), .inA(inA), .inB(inB),
    .outValid(outValid), .outResult(outResult), .outCarry(outCarry), .outZero(outZero),
    .cfgWe(cfgWe), .cfgAddr(cfgAddr), .cfgWdata(cfgWdata), .cfgRdata(cfgRdata)
  );

  always #10 clk = ~clk;

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
      failCount++;
    end else begin
      passCount++;
    end
  endtask

  // Reference shift rules applied one position per step
  function automatic logic [DataWidth-1:0] shiftModel(input logic [DataWidth-1:0] a,
                                                      input logic [4:0] amt, input ShiftOp mode);
    logic [DataWidth-1:0] r;
    r = a;
    for (int i = 0; i < amt; i++) begin
      case (mode)
        RotL:    r = {r[DataWidth-2:0], r[DataWidth-1]};
        ShftL:   r = r << 1;
        RotR:    r = {r[0], r[DataWidth-1:1]};
        default: r = r >> 1;
      endcase
    end
    return r;
  endfunction

  // Drive one operation for the DUT to sample on the following edge
  task automatic issueOp(input AluOp op, input logic [31:0] a, input logic [31:0] b,
                         input logic [33:0] expected, input string name);
    @(posedge clk);
    inValid <= 1'b1;
    inOp    <= op;
    inA     <= a;
    inB     <= b;
    cfgWe   <= 1'b0;
    expQ.push_back(expected);
    nameQ.push_back(name);
    issueQ.push_back(cycle + 1);
  endtask

  task automatic writeReg(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk);
    inValid  <= 1'b0;
    cfgWe    <= 1'b1;
    cfgAddr  <= addr[CfgAddrWidth-1:0];
    cfgWdata <= data;
  endtask

  task automatic readReg(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk);
    cfgWe   <= 1'b0;
    cfgAddr <= addr[CfgAddrWidth-1:0];
    @(posedge clk);
    data = cfgRdata;
  endtask

  // Idle until every issued operation has returned
  task automatic drain();
    int waited;
    waited = 0;
    while (expQ.size() != 0 && waited < 50) begin
      @(posedge clk);
      inValid <= 1'b0;
      cfgWe   <= 1'b0;
      waited++;
    end
    if (expQ.size() != 0) begin
      $display("ERROR: %0d results never arrived within 50 cycles", expQ.size());
      failCount++;
      expQ.delete();
      nameQ.delete();
      issueQ.delete();
    end
  endtask

  task automatic finishTest(input string name, input int failsBefore);
    $display("Test %s done, %0d errors", name, failCount - failsBefore);
  endtask

  // In-order result compare plus latency
  always @(posedge clk) begin : monitor
    logic [33:0] expected;
    string       name;
    int          issued;
    cycle <= cycle + 1;
    if (!rst && outValid) begin
      resultCount++;
      if (expQ.size() == 0) begin
        $display("ERROR: result %h arrived with no operation outstanding", outResult);
        failCount++;
      end else begin
        expected = expQ.pop_front();
        name     = nameQ.pop_front();
        issued   = issueQ.pop_front();
        checkValue({name, " result"}, expected[31:0], outResult);
        checkValue({name, " carry"}, expected[32], outCarry);
        checkValue({name, " zero"}, expected[33], outZero);
        checkValue({name, " latency"}, 2, cycle - issued);
      end
    end
  end

  initial begin
    int          fd, code, mark, op, opNum;
    logic [7:0]  kind;
    logic [31:0] a, b, res, carry, zero, addr, data;
    logic [799:0] skipBuf;
    clk      = 1'b0;
    rst      = 1'b1;
    inValid  = 1'b0;
    inOp     = OpAdd;
    inA      = '0;
    inB      = '0;
    cfgWe    = 1'b0;
    cfgAddr  = '0;
    cfgWdata = '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Quiet output and register defaults after reset
    mark = failCount;
    repeat (4) begin
      @(posedge clk);
      checkValue("reset outValid", 0, outValid);
    end
    readReg(0, data);
    checkValue("reset mode", RotL, data);
    readReg(1, data);
    checkValue("reset count", 0, data);
    finishTest("reset", mark);

    // File vectors issued back to back between config writes
    mark = failCount;
    opNum = 0;
    fd = $fopen("bench/aluStim.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open stimulus file bench/aluStim.txt");
      failCount++;
    end else begin
      while ($fscanf(fd, " %c", kind) == 1) begin
        if (kind == "#") begin
          code = $fgets(skipBuf, fd);
        end else if (kind == "C") begin
          code = $fscanf(fd, "%h %h", addr, data);
          if (code != 2) begin
            $display("ERROR: stimulus configuration line is malformed");
            failCount++;
          end else begin
            writeReg(addr, data);
          end
        end else begin
          code = $fscanf(fd, "%d %h %h %h %h %h", op, a, b, res, carry, zero);
          opNum++;
          // Skip a line that did not give all six fields
          if (code != 6) begin
            $display("ERROR: stimulus operation line %0d is malformed", opNum);
            failCount++;
          end else begin
            issueOp(AluOp'(op), a, b, {zero[0], carry[0], res},
                    $sformatf("stim op %0d", opNum));
          end
        end
      end
      $fclose(fd);
    end
    drain();
    finishTest("vectors", mark);

    // Random shifts in every mode
    mark = failCount;
    for (int m = 0; m < 4; m++) begin
      writeReg(0, m);
      repeat (6) begin
        a   = $random(seed);
        b   = $random(seed);
        res = shiftModel(a, b[4:0], ShiftOp'(m));
        issueOp(OpShift, a, b, {res == 0, 1'b0, res}, $sformatf("random mode %0d", m));
      end
    end
    drain();
    // Mode register keeps the last write
    readReg(0, data);
    checkValue("mode readback", ShftR, data);
    finishTest("random", mark);

    // Counter follows results and a write clears it
    mark = failCount;
    readReg(1, data);
    checkValue("count", resultCount, data);
    writeReg(1, 0);
    readReg(1, data);
    checkValue("count clear", 0, data);
    finishTest("counter", mark);

    $display("Checks: %0d passed, %0d failed", passCount, failCount);
    if (failCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: hw/aluTop.sv
// ALU execution unit top level
`timescale 1ns/10ps

module aluTop #(
  parameter int Width = aluPkg::DataWidth
) (
  input  logic                              clk,
  input  logic                              rst,
  // Operation path
  input  logic                              inValid,
  input  aluPkg::AluOp                      inOp,
  input  logic [Width-1:0]                  inA,
  input  logic [Width-1:0]                  inB,
  output logic                              outValid,
  output logic [Width-1:0]                  outResult,
  output logic                              outCarry,
  output logic                              outZero,
  // Configuration path
  input  logic                              cfgWe,
  input  logic [aluPkg::CfgAddrWidth-1:0]   cfgAddr,
  input  logic [aluPkg::DataWidth-1:0]      cfgWdata,
  output logic [aluPkg::DataWidth-1:0]      cfgRdata
);
  import shiftPkg::*;

  // Mode from the register block into the shifter
  ShiftOp shiftMode;

  aluCore #(.Width(Width)) core (
    .clk(clk),
    .rst(rst),
    .inValid(inValid),
    .inOp(inOp),
    .inA(inA),
    .inB(inB),
    .shiftMode(shiftMode),
    .outValid(outValid),
    .outResult(outResult),
    .outCarry(outCarry),
    .outZero(outZero)
  );

  // Each valid result bumps the counter
  ctrlRegs regs (
    .clk(clk),
    .rst(rst),
    .cfgWe(cfgWe),
    .cfgAddr(cfgAddr),
    .cfgWdata(cfgWdata),
    .cfgRdata(cfgRdata),
    .resultStrobe(outValid),
    .shiftMode(shiftMode)
  );

endmodule

// File: hw/ctrlRegs.sv
// Configuration and status registers
`timescale 1ns/10ps

module ctrlRegs (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cfgWe,
  input  logic [aluPkg::CfgAddrWidth-1:0]   cfgAddr,
  input  logic [aluPkg::DataWidth-1:0]      cfgWdata,
  output logic [aluPkg::DataWidth-1:0]      cfgRdata,
  input  logic                              resultStrobe,
  output shiftPkg::ShiftOp                  shiftMode
);
  import aluPkg::*;
  import shiftPkg::*;

  // Register map
  localparam logic [CfgAddrWidth-1:0] AddrMode  = 0;
  localparam logic [CfgAddrWidth-1:0] AddrCount = 1;

  // Completed results, wraps at 2^32
  logic [DataWidth-1:0] opCount;

  always_ff @(posedge clk) begin
    if (rst) begin
      shiftMode <= RotL;
    end else if (cfgWe && cfgAddr == AddrMode) begin
      shiftMode <= ShiftOp'(cfgWdata[1:0]);
    end
  end

  // Clear takes priority over a result on the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      opCount <= '0;
    end else if (cfgWe && cfgAddr == AddrCount) begin
      opCount <= '0;
    end else if (resultStrobe) begin
      opCount <= opCount + 1'b1;
    end
  end

  // Readback of the addressed register
  always_comb begin
    case (cfgAddr)
      AddrMode:  cfgRdata = {{(DataWidth-2){1'b0}}, shiftMode};
      AddrCount: cfgRdata = opCount;
      default:   cfgRdata = '0;
    endcase
  end

  cfgAddrKnown: assert property (@(posedge clk) disable iff (rst)
    cfgWe |-> !$isunknown(cfgAddr));

endmodule

// File: hw/aluCore.sv
// Pipelined ALU core
`timescale 1ns/10ps

module aluCore #(
  parameter int Width = aluPkg::DataWidth
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         inValid,
  input  aluPkg::AluOp                 inOp,
  input  logic             [Width-1:0] inA,
  input  logic             [Width-1:0] inB,
  input  shiftPkg::ShiftOp             shiftMode,
  output logic                         outValid,
  output logic             [Width-1:0] outResult,
  output logic                         outCarry,
  output logic                         outZero
);
  import aluPkg::*;
  import shiftPkg::*;

  // Shared adder, B inverted with carry in for subtract
  logic [Width-1:0] addB;
  logic [Width:0]   sum;

  // Stage one result before registering
  logic [Width-1:0] aluResult;
  logic             aluCarry;

  // Pipeline stage one
  logic [Width-1:0] s1Result;
  logic             s1Carry;
  AluOp             s1Op;
  logic             s1Valid;

  // Pipeline stage two, lines up with the shifter output
  logic [Width-1:0] s2Result;
  logic             s2Carry;
  AluOp             s2Op;

  // Shifter return path
  logic [Width-1:0] shResult;
  logic             shValid;

  assign addB = (inOp == OpSub) ? ~inB : inB;
  assign sum  = {1'b0, inA} + {1'b0, addB} + {{Width{1'b0}}, inOp == OpSub};

  always_comb begin
    aluCarry = 1'b0;
    case (inOp)
      OpAdd, OpSub: begin
        aluResult = sum[Width-1:0];
        aluCarry  = sum[Width];
      end
      OpAnd:   aluResult = inA & inB;
      OpOr:    aluResult = inA | inB;
      OpXor:   aluResult = inA ^ inB;
      // Shift result comes from the barrel shifter
      default: aluResult = '0;
    endcase
  end

  barrelShifter #(.Width(Width)) shifter (
    .clk(clk),
    .rst(rst),
    .in(inA),
    .amt(inB[ShiftAmtWidth-1:0]),
    .op(shiftMode),
    .inValid(inValid),
    .out(shResult),
    .outValid(shValid)
  );

  // Two register delay to match the shifter
  always_ff @(posedge clk) begin
    if (rst) begin
      s1Result <= '0;
      s1Carry  <= 1'b0;
      s1Op     <= OpAdd;
      s1Valid  <= 1'b0;
      s2Result <= '0;
      s2Carry  <= 1'b0;
      s2Op     <= OpAdd;
      outValid <= 1'b0;
    end else begin
      s1Result <= aluResult;
      s1Carry  <= aluCarry;
      s1Op     <= inOp;
      s1Valid  <= inValid;
      s2Result <= s1Result;
      s2Carry  <= s1Carry;
      s2Op     <= s1Op;
      outValid <= s1Valid;
    end
  end

  // Final select after the output registers
  assign outResult = (s2Op == OpShift) ? shResult : s2Result;
  assign outCarry  = s2Carry;
  assign outZero   = (outResult == '0);

  outValidKnown: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(outValid));

  // Shifter and core pipelines stay in lockstep
  shifterAligned: assert property (@(posedge clk) disable iff (rst)
    shValid == outValid);

endmodule

// File: hw/barrelShifter.sv
// Two cycle barrel shifter
`timescale 1ns/10ps

module barrelShifter #(
  parameter int Width = aluPkg::DataWidth
) (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic             [Width-1:0]          in,
  input  logic [shiftPkg::ShiftAmtWidth-1:0]    amt,
  input  shiftPkg::ShiftOp                      op,
  input  logic                                  inValid,
  output logic             [Width-1:0]          out,
  output logic                                  outValid
);
  import shiftPkg::*;

  // First half, distances 1, 2 and 4
  logic [Width-1:0] dist1Out;
  logic [Width-1:0] dist2Out;
  logic [Width-1:0] dist4Out;

  // Middle pipeline register
  logic [Width-1:0]           midData;
  logic [ShiftAmtWidth-1:3]   midAmt;
  ShiftOp                     midOp;
  logic                       midValid;

  // Second half, distances 8 and 16
  logic [Width-1:0] dist8Out;
  logic [Width-1:0] dist16Out;

  shiftStage #(.Width(Width), .Distance(1)) stage1 (
    .in(in), .op(op), .sel(amt[0]), .out(dist1Out)
  );
  shiftStage #(.Width(Width), .Distance(2)) stage2 (
    .in(dist1Out), .op(op), .sel(amt[1]), .out(dist2Out)
  );
  shiftStage #(.Width(Width), .Distance(4)) stage4 (
    .in(dist2Out), .op(op), .sel(amt[2]), .out(dist4Out)
  );

  // Partial result plus what the later stages still need
  always_ff @(posedge clk) begin
    if (rst) begin
      midData  <= '0;
      midAmt   <= '0;
      midOp    <= RotL;
      midValid <= 1'b0;
    end else begin
      midData  <= dist4Out;
      midAmt   <= amt[ShiftAmtWidth-1:3];
      midOp    <= op;
      midValid <= inValid;
    end
  end

  shiftStage #(.Width(Width), .Distance(8)) stage8 (
    .in(midData), .op(midOp), .sel(midAmt[3]), .out(dist8Out)
  );
  shiftStage #(.Width(Width), .Distance(16)) stage16 (
    .in(dist8Out), .op(midOp), .sel(midAmt[4]), .out(dist16Out)
  );

  // Output register
  always_ff @(posedge clk) begin
    if (rst) begin
      out      <= '0;
      outValid <= 1'b0;
    end else begin
      out      <= dist16Out;
      outValid <= midValid;
    end
  end

  // Mode and amount must be driven for every valid request
  validCtrlKnown: assert property (@(posedge clk) disable iff (rst)
    inValid |-> !$isunknown({op, amt}));

endmodule

// File: hw/shiftStage.sv
// Fixed distance shift stage
`timescale 1ns/10ps

module shiftStage #(
  parameter int Width    = aluPkg::DataWidth,
  parameter int Distance = 1
) (
  input  logic             [Width-1:0] in,
  input  shiftPkg::ShiftOp             op,
  input  logic                         sel,
  output logic             [Width-1:0] out
);
  import shiftPkg::*;

  // Word moved by Distance in the requested mode
  logic [Width-1:0] moved;

  always_comb begin
    case (op)
      // Upper bits wrap into the bottom
      RotL:    moved = {in[Width-Distance-1:0], in[Width-1:Width-Distance]};
      ShftL:   moved = {in[Width-Distance-1:0], {Distance{1'b0}}};
      // Lower bits wrap into the top
      RotR:    moved = {in[Distance-1:0], in[Width-1:Distance]};
      ShftR:   moved = {{Distance{1'b0}}, in[Width-1:Distance]};
      default: moved = in;
    endcase
  end

  // Pass through unless this stage is selected
  assign out = sel ? moved : in;

endmodule

// File: hw/shiftPkg.sv
// Shifter mode definitions
package shiftPkg;

  // Shift amount taken from operand B
  parameter int ShiftAmtWidth = 5;

  // Shift modes
  // Right shift is logical with zero fill
  typedef enum logic [1:0] {
    RotL  = 2'b00,
    ShftL = 2'b01,
    RotR  = 2'b10,
    ShftR = 2'b11
  } ShiftOp;

endpackage

// File: hw/aluPkg.sv
// ALU operation definitions
package aluPkg;

  // Operand and result width
  parameter int DataWidth = 32;

  // Configuration register address width
  parameter int CfgAddrWidth = 1;

  // Operation codes
  typedef enum logic [2:0] {
    OpAdd   = 3'd0,
    OpSub   = 3'd1,
    OpAnd   = 3'd2,
    OpOr    = 3'd3,
    OpXor   = 3'd4,
    OpShift = 3'd5
  } AluOp;

endpackage
